// ==== hdl/fe_settings.svh ====
/*
 * Fetch front end widths and instruction memory geometry
 */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// Program counter and instruction word
`define FE_VADDR_WIDTH 32
`define FE_INSTR_WIDTH 32

// On-chip instruction memory, one instruction per word
`define FE_IMEM_WORDS 256
`define FE_IMEM_ADDR_WIDTH 8

`endif

// ==== hdl/fe_pkg.sv ====
/*
 * Fetch front end types: command opcodes, queue message kinds,
 * exception codes and the queue payload word
 */
`include "fe_settings.svh"

package fe_pkg;

  typedef enum logic
  {
    e_op_redirect = 1'b0
    , e_op_wait   = 1'b1
  } fe_cmd_op_e;

  typedef enum logic
  {
    e_fe_fetch       = 1'b0
    , e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Same numbering as the RISC-V cause codes
  typedef enum logic [1:0]
  {
    e_instr_misaligned     = 2'd0
    , e_instr_access_fault = 2'd1
  } fe_exc_code_e;

  typedef struct packed
  {
    logic [`FE_INSTR_WIDTH-1:0] instr;
  } fe_fetch_s;

  typedef struct packed
  {
    logic [`FE_INSTR_WIDTH-3:0] padding;
    fe_exc_code_e               exception_code;
  } fe_exception_s;

  // Decoded by the consumer according to the message kind
  typedef union packed
  {
    fe_fetch_s     fetch;
    fe_exception_s exception;
  } fe_payload_u;

endpackage

// ==== hdl/fe_control.sv ====
/*
 * Fetch controller: wait/run/stall FSM with command decode
 */
module fe_control
  (input                        clk_i
  , input                       reset_i

  , input                       cmd_v_i
  , input fe_pkg::fe_cmd_op_e   cmd_op_i
  , output logic                cmd_ready_o

  , input                       queue_ready_i
  , input                       if2_v_i
  , input                       if2_exc_i
  , input                       fetch_fail_i

  , output logic                fetch_v_o
  , output logic                redirect_v_o
  , output logic                flush_o
  );

  localparam logic [1:0] state_wait_lp  = 2'd0;
  localparam logic [1:0] state_run_lp   = 2'd1;
  localparam logic [1:0] state_stall_lp = 2'd2;

  logic [1:0] state_r, state_n;
  logic       ready_r;

  wire cmd_taken    = cmd_v_i & ready_r;
  wire redirect_cmd = cmd_taken & (cmd_op_i == fe_pkg::e_op_redirect);
  wire wait_cmd     = cmd_taken & (cmd_op_i == fe_pkg::e_op_wait);

  wire is_run   = (state_r == state_run_lp);
  wire is_stall = (state_r == state_stall_lp);

  // Exception leaves IF2 this cycle
  wire exc_done = is_run & if2_v_i & if2_exc_i & queue_ready_i & ~cmd_taken;
  wire unstall  = is_stall & queue_ready_i & ~cmd_taken;

  always_comb
  begin
    state_n = state_r;
    if (redirect_cmd)
      state_n = state_run_lp;
    else if (wait_cmd)
      state_n = state_wait_lp;
    else
      case (state_r)
        state_run_lp:
          if (fetch_fail_i)
            state_n = state_stall_lp;
          else if (exc_done)
            state_n = state_wait_lp;
        state_stall_lp:
          if (queue_ready_i)
            state_n = state_run_lp;
        default: state_n = state_wait_lp;
      endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= state_wait_lp;
      ready_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      ready_r <= 1'b1;
    end
  end

  assign cmd_ready_o  = ready_r;
  assign fetch_v_o    = is_run;
  // Stall exit replays from the resume PC
  assign redirect_v_o = redirect_cmd | unstall;
  assign flush_o      = cmd_taken | fetch_fail_i;

endmodule

// ==== hdl/fe_pc_gen.sv ====
/*
 * PC generator: sequential fetch PC plus a resume PC for replay
 */
`include "fe_settings.svh"

module fe_pc_gen
  (input                                clk_i
  , input                               reset_i

  , input                               fetch_v_i
  , input                               redirect_v_i
  , input                               cmd_taken_i
  , input [`FE_VADDR_WIDTH-1:0]         cmd_pc_i
  , input [`FE_VADDR_WIDTH-1:0]         if2_pc_i

  , output logic [`FE_VADDR_WIDTH-1:0]  next_pc_o
  );

  localparam logic [`FE_VADDR_WIDTH-1:0] pc_step_lp = 4;

  logic [`FE_VADDR_WIDTH-1:0] fetch_pc_r;
  logic [`FE_VADDR_WIDTH-1:0] resume_pc_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      fetch_pc_r  <= '0;
      resume_pc_r <= '0;
    end
    else
    begin
      // Redirect wins over the sequential step
      if (redirect_v_i)
        fetch_pc_r <= cmd_taken_i ? cmd_pc_i : resume_pc_r;
      else if (fetch_v_i)
        fetch_pc_r <= fetch_pc_r + pc_step_lp;

      // Holds the oldest PC not yet delivered
      if (cmd_taken_i)
        resume_pc_r <= cmd_pc_i;
      else if (fetch_v_i)
        resume_pc_r <= if2_pc_i;
    end
  end

  assign next_pc_o = fetch_pc_r;

endmodule

// ==== hdl/fe_imem.sv ====
/*
 * Instruction memory with write port, registered read and PC checks
 */
`include "fe_settings.svh"

module fe_imem
  (input                                clk_i

  , input                               imem_w_v_i
  , input [`FE_IMEM_ADDR_WIDTH-1:0]     imem_w_addr_i
  , input [`FE_INSTR_WIDTH-1:0]         imem_w_data_i

  , input                               rd_v_i
  , input [`FE_VADDR_WIDTH-1:0]         rd_pc_i

  , output logic [`FE_INSTR_WIDTH-1:0]  instr_o
  , output logic                        misaligned_o
  , output logic                        access_fault_o
  );

  localparam logic [`FE_VADDR_WIDTH-1:0] mem_bytes_lp = 4 * `FE_IMEM_WORDS;

  logic [`FE_INSTR_WIDTH-1:0] mem_r [`FE_IMEM_WORDS];

  wire [`FE_IMEM_ADDR_WIDTH-1:0] rd_idx = rd_pc_i[`FE_IMEM_ADDR_WIDTH+1:2];
  wire misaligned   = (rd_pc_i[1:0] != 2'b00);
  wire out_of_range = (rd_pc_i >= mem_bytes_lp);

  always_ff @(posedge clk_i)
  begin
    if (imem_w_v_i)
      mem_r[imem_w_addr_i] <= imem_w_data_i;

    if (rd_v_i)
    begin
      instr_o        <= mem_r[rd_idx];
      misaligned_o   <= misaligned;
      // Misalignment reported first
      access_fault_o <= ~misaligned & out_of_range;
    end
  end

endmodule

// ==== hdl/fe_fetch_pipe.sv ====
/*
 * Two-stage fetch pipe (IF1, IF2) and fetch queue message formation
 */
`include "fe_settings.svh"

module fe_fetch_pipe
  (input                                clk_i
  , input                               reset_i

  , input                               fetch_v_i
  , input                               flush_i
  , input                               queue_ready_i
  , input [`FE_VADDR_WIDTH-1:0]         next_pc_i
  , input [`FE_INSTR_WIDTH-1:0]         instr_i
  , input                               misaligned_i
  , input                               access_fault_i

  , output logic                        if2_v_o
  , output logic                        if2_exc_o
  , output logic [`FE_VADDR_WIDTH-1:0]  if2_pc_o
  , output logic                        fetch_fail_o

  , output logic                        queue_v_o
  , output fe_pkg::fe_msg_type_e        queue_type_o
  , output logic [`FE_VADDR_WIDTH-1:0]  queue_pc_o
  , output fe_pkg::fe_payload_u         queue_payload_o
  );

  logic                         if1_v_r, if2_v_r;
  logic [`FE_VADDR_WIDTH-1:0]   if1_pc_r, if2_pc_r;
  logic [`FE_INSTR_WIDTH-1:0]   if2_instr_r;
  logic                         if2_misaligned_r, if2_access_fault_r;

  // A delivered exception ends the stream, so younger fetches die with it
  wire exc_sent = queue_v_o & if2_exc_o;
  wire kill     = flush_i | exc_sent;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_v_r <= 1'b0;
      if2_v_r <= 1'b0;
    end
    else
    begin
      if1_v_r <= fetch_v_i & ~kill;
      if2_v_r <= if1_v_r & ~kill;
    end
  end

  // Memory output lines up with IF1
  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
      if1_pc_r <= next_pc_i;
    if (if1_v_r)
    begin
      if2_pc_r           <= if1_pc_r;
      if2_instr_r        <= instr_i;
      if2_misaligned_r   <= misaligned_i;
      if2_access_fault_r <= access_fault_i;
    end
  end

  assign if2_v_o      = if2_v_r;
  assign if2_exc_o    = if2_misaligned_r | if2_access_fault_r;
  assign if2_pc_o     = if2_pc_r;
  assign fetch_fail_o = if2_v_r & ~queue_ready_i;

  // Valid only with ready, never held
  assign queue_v_o  = if2_v_r & queue_ready_i & ~flush_i;
  assign queue_pc_o = if2_pc_r;

  always_comb
  begin
    queue_payload_o = '0;
    if (if2_exc_o)
    begin
      queue_type_o = fe_pkg::e_fe_exception;
      queue_payload_o.exception.exception_code = if2_misaligned_r
                                                 ? fe_pkg::e_instr_misaligned
                                                 : fe_pkg::e_instr_access_fault;
    end
    else
    begin
      queue_type_o = fe_pkg::e_fe_fetch;
      queue_payload_o.fetch.instr = if2_instr_r;
    end
  end

endmodule

// ==== hdl/fe_top.sv ====
/*
 * Instruction fetch front end top: controller, PC generator,
 * instruction memory and fetch pipe
 */
`include "fe_settings.svh"

module fe_top
  (input                                clk_i
  , input                               reset_i

  , input                               cmd_v_i
  , input fe_pkg::fe_cmd_op_e           cmd_op_i
  , input [`FE_VADDR_WIDTH-1:0]         cmd_pc_i
  , output logic                        cmd_ready_o

  , output logic                        queue_v_o
  , output fe_pkg::fe_msg_type_e        queue_type_o
  , output logic [`FE_VADDR_WIDTH-1:0]  queue_pc_o
  , output fe_pkg::fe_payload_u         queue_payload_o
  , input                               queue_ready_i

  , input                               imem_w_v_i
  , input [`FE_IMEM_ADDR_WIDTH-1:0]     imem_w_addr_i
  , input [`FE_INSTR_WIDTH-1:0]         imem_w_data_i
  );

  logic                       fetch_v, redirect_v, flush;
  logic [`FE_VADDR_WIDTH-1:0] next_pc, if2_pc;
  logic [`FE_INSTR_WIDTH-1:0] instr;
  logic                       misaligned, access_fault;
  logic                       if2_v, if2_exc, fetch_fail;

  wire cmd_taken = cmd_v_i & cmd_ready_o;

  fe_control control0
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(cmd_v_i)
    , .cmd_op_i(cmd_op_i)
    , .cmd_ready_o(cmd_ready_o)
    , .queue_ready_i(queue_ready_i)
    , .if2_v_i(if2_v)
    , .if2_exc_i(if2_exc)
    , .fetch_fail_i(fetch_fail)
    , .fetch_v_o(fetch_v)
    , .redirect_v_o(redirect_v)
    , .flush_o(flush)
    );

  fe_pc_gen pc_gen0
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .fetch_v_i(fetch_v)
    , .redirect_v_i(redirect_v)
    , .cmd_taken_i(cmd_taken)
    , .cmd_pc_i(cmd_pc_i)
    , .if2_pc_i(if2_pc)
    , .next_pc_o(next_pc)
    );

  fe_imem imem0
    (.clk_i(clk_i)
    , .imem_w_v_i(imem_w_v_i)
    , .imem_w_addr_i(imem_w_addr_i)
    , .imem_w_data_i(imem_w_data_i)
    , .rd_v_i(fetch_v)
    , .rd_pc_i(next_pc)
    , .instr_o(instr)
    , .misaligned_o(misaligned)
    , .access_fault_o(access_fault)
    );

  fe_fetch_pipe fetch_pipe0
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .fetch_v_i(fetch_v)
    , .flush_i(flush)
    , .queue_ready_i(queue_ready_i)
    , .next_pc_i(next_pc)
    , .instr_i(instr)
    , .misaligned_i(misaligned)
    , .access_fault_i(access_fault)
    , .if2_v_o(if2_v)
    , .if2_exc_o(if2_exc)
    , .if2_pc_o(if2_pc)
    , .fetch_fail_o(fetch_fail)
    , .queue_v_o(queue_v_o)
    , .queue_type_o(queue_type_o)
    , .queue_pc_o(queue_pc_o)
    , .queue_payload_o(queue_payload_o)
    );

endmodule

// ==== tb/fe_assertions.sv ====
/*
 * Queue and command port protocol rules of the fetch front end
 */
module fe_assertions
  (input   clk_i
  , input  reset_i
  , input  cmd_v_i
  , input  cmd_ready_o
  , input  queue_v_o
  , input  queue_ready_i
  );

  // Queue valid only rises together with ready
  queue_v_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    queue_v_o |-> queue_ready_i)
  else $error("queue_v_o high while queue_ready_i is low");

  // Reset edge already seen, so ready must be down
  cmd_ready_low_in_reset: assert property (@(posedge clk_i)
    ($past(reset_i) && reset_i) |-> !cmd_ready_o)
  else $error("cmd_ready_o high during reset");

  no_message_on_command: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_i && cmd_ready_o) |-> !queue_v_o)
  else $error("queue message in a cycle with an accepted command");

endmodule

bind fe_top fe_assertions assertions0
  (.clk_i(clk_i)
  , .reset_i(reset_i)
  , .cmd_v_i(cmd_v_i)
  , .cmd_ready_o(cmd_ready_o)
  , .queue_v_o(queue_v_o)
  , .queue_ready_i(queue_ready_i)
  );

// ==== tb/fe_tb.sv ====
/*
 * Testbench for the fetch front end: file-driven commands,
 * reference model of the expected queue stream
 */
`include "fe_settings.svh"

module fe_tb;

  localparam logic [`FE_VADDR_WIDTH-1:0] mem_bytes_lp = 4 * `FE_IMEM_WORDS;

  logic                             clk_i = 1'b0;
  logic                             reset_i;
  logic                             cmd_v_i;
  fe_pkg::fe_cmd_op_e               cmd_op_i;
  logic [`FE_VADDR_WIDTH-1:0]       cmd_pc_i;
  logic                             cmd_ready_o;
  logic                             queue_v_o;
  fe_pkg::fe_msg_type_e             queue_type_o;
  logic [`FE_VADDR_WIDTH-1:0]       queue_pc_o;
  fe_pkg::fe_payload_u              queue_payload_o;
  logic                             queue_ready_i;
  logic                             imem_w_v_i;
  logic [`FE_IMEM_ADDR_WIDTH-1:0]   imem_w_addr_i;
  logic [`FE_INSTR_WIDTH-1:0]       imem_w_data_i;

  logic [31:0]                  records [0:127];
  logic [`FE_INSTR_WIDTH-1:0]   mem_model [`FE_IMEM_WORDS];
  logic [`FE_VADDR_WIDTH-1:0]   exp_pc;
  logic                         stopped;
  logic                         random_ready;
  logic                         cmd_seen;
  integer                       seed = 32'h305f;
  int unsigned                  cycle_count = 0;
  int unsigned                  cycle_limit = 32'hffff_ffff;
  int unsigned                  msgs_in_run;

  fe_top dut0
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(cmd_v_i)
    , .cmd_op_i(cmd_op_i)
    , .cmd_pc_i(cmd_pc_i)
    , .cmd_ready_o(cmd_ready_o)
    , .queue_v_o(queue_v_o)
    , .queue_type_o(queue_type_o)
    , .queue_pc_o(queue_pc_o)
    , .queue_payload_o(queue_payload_o)
    , .queue_ready_i(queue_ready_i)
    , .imem_w_v_i(imem_w_v_i)
    , .imem_w_addr_i(imem_w_addr_i)
    , .imem_w_data_i(imem_w_data_i)
    );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // Background contents where every address bit shows up in the word
  function automatic logic [`FE_INSTR_WIDTH-1:0] fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    fill_word = {a, ~a, a ^ 8'ha5, 8'h13};
  endfunction

  // Two cycles of pipe fill and then one message per cycle up to the closing exception
  function automatic int unsigned expected_count(input logic [31:0] pc,
                                                 input int unsigned len);
    int unsigned stream;
    int unsigned window;
    if ((pc[1:0] != 2'b00) || (pc >= mem_bytes_lp))
      stream = 1;
    else
      stream = (mem_bytes_lp - pc) / 4 + 1;
    window = (len > 2) ? len - 2 : 0;
    expected_count = (window < stream) ? window : stream;
  endfunction

  task automatic fail_stop(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_message();
    logic [`FE_VADDR_WIDTH-1:0] pc;
    fe_pkg::fe_exc_code_e       code;
    pc = queue_pc_o;
    assert (!stopped)
    else fail_stop($sformatf("unexpected message with pc %h", pc));
    assert (pc == exp_pc)
    else fail_stop($sformatf("pc %h, expected %h", pc, exp_pc));
    if ((pc[1:0] != 2'b00) || (pc >= mem_bytes_lp))
    begin
      code = (pc[1:0] != 2'b00) ? fe_pkg::e_instr_misaligned : fe_pkg::e_instr_access_fault;
      assert ((queue_type_o == fe_pkg::e_fe_exception)
              && (queue_payload_o.exception.exception_code == code))
      else fail_stop($sformatf("pc %h should give exception code %0d", pc, code));
      // Nothing more until the next redirect
      stopped = 1'b1;
    end
    else
    begin
      assert ((queue_type_o == fe_pkg::e_fe_fetch)
              && (queue_payload_o.fetch.instr == mem_model[pc[`FE_IMEM_ADDR_WIDTH+1:2]]))
      else fail_stop($sformatf("pc %h instr %h, expected %h", pc,
                               queue_payload_o.fetch.instr,
                               mem_model[pc[`FE_IMEM_ADDR_WIDTH+1:2]]));
      exp_pc = exp_pc + 4;
    end
    msgs_in_run = msgs_in_run + 1;
  endtask

  // Sample the queue at the edge and then drive ready for the next cycle
  task automatic tick();
    @(posedge clk_i);
    cmd_seen = cmd_v_i & cmd_ready_o;
    if (queue_v_o)
      check_message();
    queue_ready_i <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic run_command(input fe_pkg::fe_cmd_op_e op, input logic [31:0] pc,
                             input int unsigned len);
    tick();
    cmd_v_i  <= 1'b1;
    cmd_op_i <= op;
    cmd_pc_i <= pc;
    do
      tick();
    while (!cmd_seen);
    cmd_v_i <= 1'b0;
    if (op == fe_pkg::e_op_redirect)
    begin
      exp_pc  = pc;
      stopped = 1'b0;
    end
    else
      stopped = 1'b1;
    msgs_in_run = 0;
    repeat (len)
      tick();
    // With the queue always ready the count is fixed by the pipe timing
    if (op == fe_pkg::e_op_redirect)
    begin
      if (random_ready)
      begin
        assert (msgs_in_run > 0)
        else fail_stop($sformatf("no message arrived after the redirect to %h", pc));
      end
      else
      begin
        assert (msgs_in_run == expected_count(pc, len))
        else fail_stop($sformatf("%0d messages after the redirect to %h, expected %0d",
                                 msgs_in_run, pc, expected_count(pc, len)));
      end
    end
  endtask

  task automatic write_word(input int idx, input logic [`FE_INSTR_WIDTH-1:0] data);
    tick();
    imem_w_v_i    <= 1'b1;
    imem_w_addr_i <= idx[`FE_IMEM_ADDR_WIDTH-1:0];
    imem_w_data_i <= data;
    mem_model[idx[`FE_IMEM_ADDR_WIDTH-1:0]] = data;
  endtask

  initial
  begin
    int unsigned total;
    int          i;
    reset_i       = 1'b1;
    cmd_v_i       = 1'b0;
    cmd_op_i      = fe_pkg::e_op_wait;
    cmd_pc_i      = '0;
    queue_ready_i = 1'b1;
    imem_w_v_i    = 1'b0;
    imem_w_addr_i = '0;
    imem_w_data_i = '0;
    stopped       = 1'b1;
    random_ready  = 1'b0;
    exp_pc        = '0;
    msgs_in_run   = 0;

    $readmemh("tb/fe_input.txt", records);
    total = 0;
    for (i = 0; (i < 128) && (records[i] != 0); i = i + 4)
      total = total + ((records[i] == 2) ? records[i+3] : 1);
    cycle_limit = (total + `FE_IMEM_WORDS + 16) * 4 + 200;

    repeat (16)
      @(posedge clk_i);
    reset_i <= 1'b0;

    for (i = 0; i < `FE_IMEM_WORDS; i = i + 1)
      write_word(i, fill_word(i));

    for (i = 0; (i < 128) && (records[i] != 0); i = i + 4)
    begin
      case (records[i])
        1: write_word(int'(records[i+1]), records[i+2]);
        2: run_command(fe_pkg::fe_cmd_op_e'(records[i+1][0]), records[i+2], records[i+3]);
        3: random_ready = records[i+1][0];
        default: fail_stop($sformatf("unknown record kind %0d", records[i]));
      endcase
      tick();
      imem_w_v_i <= 1'b0;
    end

    repeat (8)
      tick();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== tb/fe_input.txt ====
// Records of four hex words: kind a b c
// kind 1 memory write (a word index, b data), 2 command (a 0 redirect 1 wait, b pc, c cycles)
// kind 3 ready mode (a 0 always ready, 1 random), kind 0 ends the list
1 00000010 deadbeef 00000000
1 000000ff 12345678 00000000
1 00000041 0badf00d 00000000
3 00000000 00000000 00000000
2 00000000 00000000 00000040
2 00000000 00000100 00000020
3 00000001 00000000 00000000
2 00000000 00000040 00000100
3 00000000 00000000 00000000
2 00000000 000003f0 00000020
2 00000000 00000080 00000008
2 00000001 00000000 00000010
2 00000000 00000102 00000010
2 00000001 00000000 00000010
2 00000000 00000020 00000040
3 00000001 00000000 00000000
2 00000000 000003c0 00000080
3 00000000 00000000 00000000
2 00000000 00000000 00000020
0 00000000 00000000 00000000

// ==== fe.f ====
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_control.sv
hdl/fe_pc_gen.sv
hdl/fe_imem.sv
hdl/fe_fetch_pipe.sv
hdl/fe_top.sv
tb/fe_assertions.sv
tb/fe_tb.sv

// ==== Makefile ====
# Verilator build of the fetch front end testbench

SRCS := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

obj_dir/Vfe_tb: fe.f $(SRCS)
	verilator --binary --timing --assert -f fe.f --top-module fe_tb -o Vfe_tb

.PHONY: run clean

run: obj_dir/Vfe_tb
	./obj_dir/Vfe_tb

clean:
	rm -rf obj_dir
